//--- include/emu_consts.svh
`ifndef EMU_CONSTS_SVH
`define EMU_CONSTS_SVH

// width of one channel data word.
`define EMU_DATA_WIDTH 32

// entries per model FIFO.
// also the host's starting downlink credit count.
`define EMU_FIFO_DEPTH 16

// uplink credits held after reset.
`define EMU_UP_CREDITS 8

// credit counters and credit message count.
`define EMU_CNT_WIDTH 8

`endif

//--- src/emu_chan_pkg.sv
`default_nettype none

`include "emu_consts.svh"

package emu_chan_pkg;

    // one word on a target channel.
    typedef logic [`EMU_DATA_WIDTH-1:0] data_word_t;

    // read token from the target.
    typedef struct packed {
        logic valid;
        logic ren;
    } read_req_t;

    // write token from the target.
    typedef struct packed {
        logic       valid;
        logic       wen;
        data_word_t data;
    } write_req_t;

endpackage

`default_nettype wire

//--- src/emu_host_pkg.sv
`default_nettype none

package emu_host_pkg;

    // word pushed down by the host.
    typedef struct packed {
        logic                    valid;
        emu_chan_pkg::data_word_t data;
    } down_word_t;

    typedef enum logic {
        MSG_DATA   = 1'b0,
        MSG_CREDIT = 1'b1
    } host_msg_kind_t;

    // uplink message.
    // for a credit return the count sits in the low payload bits.
    typedef struct packed {
        host_msg_kind_t          kind;
        emu_chan_pkg::data_word_t payload;
    } host_msg_t;

endpackage

`default_nettype wire

//--- src/emu_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module emu_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  wire  mdl_clk,
    input  wire  rst,
    input  wire  push,
    input  wire  T push_data,
    input  wire  pop,
    output T     head,
    output logic empty,
    output logic full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    // requests against a full or empty buffer are dropped here.
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge mdl_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge mdl_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == AW'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == AW'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);
    assign full  = (count == (AW + 1)'(DEPTH));
    assign head  = mem[rd_ptr];

endmodule

`default_nettype wire

//--- src/emu_data_source.sv
`timescale 1ns/100ps
`default_nettype none

`include "emu_consts.svh"

module emu_data_source (
    input  wire                       mdl_clk,
    input  wire                       rst,
    input  wire emu_host_pkg::down_word_t dn,
    input  wire emu_chan_pkg::read_req_t  rd,
    output logic                      rd_ready,
    output emu_chan_pkg::data_word_t  rdata,
    output logic                      credit_ret
);

    import emu_chan_pkg::*;

    logic rempty;
    logic rd_fire;

    // host credits keep dn from ever hitting a full FIFO.
    emu_fifo #(
        .T         (data_word_t),
        .DEPTH     (`EMU_FIFO_DEPTH)
    ) i_fifo (
        .mdl_clk   (mdl_clk),
        .rst       (rst),
        .push      (dn.valid),
        .push_data (dn.data),
        .pop       (rd_fire),
        .head      (rdata),
        .empty     (rempty),
        .full      ()
    );

    assign rd_ready = !rempty;

    // complete read token.
    assign rd_fire = rd.valid && rd.ren && rd_ready;

    // one slot freed per consumed word.
    assign credit_ret = rd_fire;

endmodule

`default_nettype wire

//--- src/emu_data_sink.sv
`timescale 1ns/100ps
`default_nettype none

`include "emu_consts.svh"

module emu_data_sink (
    input  wire                       mdl_clk,
    input  wire                       rst,
    input  wire emu_chan_pkg::write_req_t wr,
    output logic                      wr_ready,
    input  wire                       sink_pop,
    output emu_chan_pkg::data_word_t  sink_head,
    output logic                      sink_avail
);

    import emu_chan_pkg::*;

    logic wfull;
    logic wempty;
    logic wr_fire;

    emu_fifo #(
        .T         (data_word_t),
        .DEPTH     (`EMU_FIFO_DEPTH)
    ) i_fifo (
        .mdl_clk   (mdl_clk),
        .rst       (rst),
        .push      (wr_fire),
        .push_data (wr.data),
        .pop       (sink_pop),
        .head      (sink_head),
        .empty     (wempty),
        .full      (wfull)
    );

    // target stalls once the uplink stops draining.
    assign wr_ready = !wfull;

    assign wr_fire = wr.valid && wr.wen && wr_ready;

    // oldest word stays on sink_head until popped.
    assign sink_avail = !wempty;

endmodule

`default_nettype wire

//--- src/emu_host_uplink.sv
`timescale 1ns/100ps
`default_nettype none

`include "emu_consts.svh"

module emu_host_uplink (
    input  wire                      mdl_clk,
    input  wire                      rst,
    input  wire emu_chan_pkg::data_word_t sink_head,
    input  wire                      sink_avail,
    output logic                     sink_pop,
    input  wire                      credit_ret,
    input  wire                      up_credit,
    output emu_host_pkg::host_msg_t  up_msg,
    output logic                     up_valid
);

    import emu_chan_pkg::*;
    import emu_host_pkg::*;

    localparam int CW = `EMU_CNT_WIDTH;

    logic [CW-1:0] pend_cnt;
    logic [CW-1:0] up_cnt;
    logic          rr_credit;
    logic          can_send;
    logic          has_credit_msg;
    logic          send_data;
    logic          send_credit;
    logic          sent;

    assign can_send       = (up_cnt != '0);
    assign has_credit_msg = (pend_cnt != '0);

    // rr_credit set means the credit message goes first on a tie.
    always_comb begin
        send_data   = 1'b0;
        send_credit = 1'b0;
        if (can_send) begin
            if (sink_avail && has_credit_msg) begin
                send_credit = rr_credit;
                send_data   = !rr_credit;
            end else begin
                send_data   = sink_avail;
                send_credit = has_credit_msg;
            end
        end
    end

    assign sent     = send_data || send_credit;
    assign sink_pop = send_data;

    always_ff @(posedge mdl_clk) begin
        if (rst) begin
            pend_cnt  <= '0;
            up_cnt    <= CW'(`EMU_UP_CREDITS);
            rr_credit <= 1'b0;
            up_valid  <= 1'b0;
        end else begin
            // a return in the sending cycle starts the next batch.
            if (send_credit) begin
                pend_cnt <= CW'(credit_ret);
            end else begin
                pend_cnt <= pend_cnt + CW'(credit_ret);
            end
            up_cnt <= up_cnt + CW'(up_credit) - CW'(sent);
            if (send_data) begin
                rr_credit <= 1'b1;
            end else if (send_credit) begin
                rr_credit <= 1'b0;
            end
            up_valid <= sent;
        end
    end

    always_ff @(posedge mdl_clk) begin
        if (send_data) begin
            up_msg.kind    <= MSG_DATA;
            up_msg.payload <= sink_head;
        end else if (send_credit) begin
            up_msg.kind    <= MSG_CREDIT;
            up_msg.payload <= data_word_t'(pend_cnt);
        end
    end

endmodule

`default_nettype wire

//--- src/emu_model_io.sv
`timescale 1ns/100ps
`default_nettype none

module emu_model_io (
    input  wire                       mdl_clk,
    input  wire                       rst,
    input  wire emu_host_pkg::down_word_t dn,
    input  wire emu_chan_pkg::read_req_t  rd,
    output logic                      rd_ready,
    output emu_chan_pkg::data_word_t  rdata,
    input  wire emu_chan_pkg::write_req_t wr,
    output logic                      wr_ready,
    input  wire                       up_credit,
    output emu_host_pkg::host_msg_t   up_msg,
    output logic                      up_valid
);

    import emu_chan_pkg::*;

    logic       credit_ret;
    data_word_t sink_head;
    logic       sink_avail;
    logic       sink_pop;

    emu_data_source i_source (
        .mdl_clk    (mdl_clk),
        .rst        (rst),
        .dn         (dn),
        .rd         (rd),
        .rd_ready   (rd_ready),
        .rdata      (rdata),
        .credit_ret (credit_ret)
    );

    emu_data_sink i_sink (
        .mdl_clk    (mdl_clk),
        .rst        (rst),
        .wr         (wr),
        .wr_ready   (wr_ready),
        .sink_pop   (sink_pop),
        .sink_head  (sink_head),
        .sink_avail (sink_avail)
    );

    emu_host_uplink i_uplink (
        .mdl_clk    (mdl_clk),
        .rst        (rst),
        .sink_head  (sink_head),
        .sink_avail (sink_avail),
        .sink_pop   (sink_pop),
        .credit_ret (credit_ret),
        .up_credit  (up_credit),
        .up_msg     (up_msg),
        .up_valid   (up_valid)
    );

endmodule

`default_nettype wire

//--- tb/tb_emu_model_io.sv
`timescale 1ns/100ps
`default_nettype none

`include "emu_consts.svh"

module tb_emu_model_io;

    import emu_chan_pkg::*;
    import emu_host_pkg::*;

    localparam int WAIT_LIMIT = 500;

    logic       mdl_clk;
    logic       rst;
    down_word_t dn;
    read_req_t  rd;
    logic       rd_ready;
    data_word_t rdata;
    write_req_t wr;
    logic       wr_ready;
    logic       up_credit;
    host_msg_t  up_msg;
    logic       up_valid;

    // host and target bookkeeping.
    data_word_t exp_q[$];
    int src_count  = 0;
    int sink_occ   = 0;
    int dn_credits = `EMU_FIFO_DEPTH;
    int reads_done = 0;
    int reads_seen = 0;
    int credit_sum = 0;
    int granted    = 0;
    int msg_count  = 0;
    bit run_checks = 1'b0;

    emu_model_io i_emu_model_io (
        .mdl_clk   (mdl_clk),
        .rst       (rst),
        .dn        (dn),
        .rd        (rd),
        .rd_ready  (rd_ready),
        .rdata     (rdata),
        .wr        (wr),
        .wr_ready  (wr_ready),
        .up_credit (up_credit),
        .up_msg    (up_msg),
        .up_valid  (up_valid)
    );

    always #2 mdl_clk = ~mdl_clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_msg(input string name, input host_msg_t got, input host_msg_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // inputs change 1 ns after the rising edge.
    task automatic next_cycle();
        @(posedge mdl_clk);
        #1;
    endtask

    task automatic wait_step(inout int waited, input string what);
        if (waited == WAIT_LIMIT) begin
            abort_run({"timeout waiting for ", what});
        end
        next_cycle();
        waited++;
    endtask

    // sampled after the monitor has seen this cycle's message.
    task automatic settle_ready_check();
        #2;
        check_flag("wr_ready", wr_ready, sink_occ != `EMU_FIFO_DEPTH);
        next_cycle();
    endtask

    task automatic push_down(input data_word_t word);
        int waited;
        waited = 0;
        while (dn_credits == 0) begin
            wait_step(waited, "a downlink credit");
        end
        dn.valid = 1'b1;
        dn.data  = word;
        next_cycle();
        dn = '0;
        src_count++;
        dn_credits--;
    endtask

    task automatic read_target(input data_word_t expected);
        int waited;
        waited = 0;
        while (!rd_ready) begin
            wait_step(waited, "rd_ready");
        end
        check_data("rdata", rdata, expected);
        rd.valid = 1'b1;
        rd.ren   = 1'b1;
        next_cycle();
        rd = '0;
        src_count--;
        reads_done++;
    endtask

    task automatic write_target(input data_word_t word);
        int waited;
        waited = 0;
        settle_ready_check();
        while (!wr_ready) begin
            wait_step(waited, "wr_ready");
        end
        wr.valid = 1'b1;
        wr.wen   = 1'b1;
        wr.data  = word;
        next_cycle();
        wr = '0;
        exp_q.push_back(word);
        sink_occ++;
    endtask

    task automatic grant_credits(input int n);
        settle_ready_check();
        for (int i = 0; i < n; i++) begin
            up_credit = 1'b1;
            granted++;
            next_cycle();
        end
        up_credit = 1'b0;
    endtask

    task automatic drain_and_check();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || credit_sum != reads_done) begin
            wait_step(waited, "the uplink to drain");
        end
        settle_ready_check();
        check_flag("rd_ready", rd_ready, src_count != 0);
        check_flag("up_valid", up_valid, 1'b0);
    endtask

    // uplink message monitor.
    always @(negedge mdl_clk) begin
        host_msg_t exp_msg;
        int        pending;
        if (run_checks) begin
            check_flag("rd_ready", rd_ready, src_count != 0);
            if (up_valid) begin
                msg_count++;
                if (msg_count > `EMU_UP_CREDITS + granted) begin
                    abort_run("uplink sent a message without an uplink credit");
                end else if (up_msg.kind == MSG_DATA) begin
                    if (exp_q.size() == 0) begin
                        abort_run("data message arrived with no outstanding write");
                    end else begin
                        exp_msg.kind    = MSG_DATA;
                        exp_msg.payload = exp_q.pop_front();
                        check_msg("up_msg", up_msg, exp_msg);
                        sink_occ--;
                    end
                end else begin
                    // carries every read completed before its send edge.
                    pending = reads_seen - credit_sum;
                    if (pending == 0) begin
                        abort_run("credit message sent with no downlink credit pending");
                    end else begin
                        exp_msg.kind    = MSG_CREDIT;
                        exp_msg.payload = data_word_t'(pending);
                        check_msg("up_msg", up_msg, exp_msg);
                        credit_sum += pending;
                        dn_credits += pending;
                    end
                end
            end
            reads_seen = reads_done;
        end
    end

    initial begin
        int          fd;
        string       line;
        byte         op;
        logic [31:0] value;
        int          cnt;
        int          n;
        void'($urandom(48538));
        mdl_clk   = 1'b0;
        rst       = 1'b1;
        dn        = '0;
        rd        = '0;
        wr        = '0;
        up_credit = 1'b0;
        repeat (5) @(posedge mdl_clk);
        #1;
        rst = 1'b0;
        check_flag("up_valid", up_valid, 1'b0);
        check_flag("rd_ready", rd_ready, 1'b0);
        check_flag("wr_ready", wr_ready, 1'b1);
        run_checks = 1'b1;
        fd = $fopen("tb/emu_model_io_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/emu_model_io_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %d", op, value, cnt);
            if (n == 3 && op != "#") begin
                for (int i = 0; i < cnt; i++) begin
                    case (op)
                        "D": push_down(value + i);
                        "R": read_target(value + i);
                        "W": write_target(value + i);
                        "G": grant_credits(int'(value));
                        "Q": drain_and_check();
                        default: abort_run($sformatf("unknown test data operation %c", op));
                    endcase
                end
                // short random idle gap between operations.
                repeat ($urandom % 3) next_cycle();
            end
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- emu_model_io.f
+incdir+include
src/emu_chan_pkg.sv
src/emu_host_pkg.sv
src/emu_fifo.sv
src/emu_data_source.sv
src/emu_data_sink.sv
src/emu_host_uplink.sv
src/emu_model_io.sv
tb/tb_emu_model_io.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f emu_model_io.f \
        --top-module tb_emu_model_io -o sim_emu_model_io \
    && ./obj_dir/sim_emu_model_io 2>&1 | tee sim.log \
    && grep -q "TB PASSED" sim.log \
    || { echo "simulation did not pass, see sim.log"; exit 1; }

//--- tb/emu_model_io_testdata.txt
# columns are op, hex value and decimal repeat count
# ops are D push down, R read and expect, W target write, G grant, Q drain
# value steps by one on each repeat, for G it is the credits per repeat
W a0000000 24
D 00000100 16
R 00000100 16
G 28 1
D 00000200 10
R 00000200 5
W b0000000 6
R 00000205 5
G 40 1
D 00000300 12
R 00000300 12
Q 0 1
